/* flist.f */
+incdir+verilog
verilog/mem_pkg.sv
verilog/unified_ram.sv
verilog/mem_arbiter.sv
verilog/inst_fetch.sv
verilog/load_store_unit.sv
verilog/mem_subsystem.sv
testbench/tb_mem_subsystem.sv

/* Bender.yml */
package:
  name: mem_subsystem

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/mem_pkg.sv
      - verilog/unified_ram.sv
      - verilog/mem_arbiter.sv
      - verilog/inst_fetch.sv
      - verilog/load_store_unit.sv
      - verilog/mem_subsystem.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - testbench/tb_mem_subsystem.sv

/* testbench/mem_vectors.hex */
// op addr size unsigned data expected; op 1 store 2 load 3 fetch run 4 redirect 5 fill 6 stress 0 end
// size 0 byte 1 half 2 word 3 double; data counts cycles for 3, words for 5, accesses for 6
5 80000000 0 0 80 0
3 0 0 0 c 0
1 80001000 3 0 8877665544332211 0
1 80001001 0 0 123456a5 0
1 80001002 1 0 9999beef 0
1 80001004 2 0 cafef00d 0
2 80001000 3 0 0 cafef00dbeefa511
1 80001008 3 0 0f0e0d0c0b0a0908 0
1 8000100f 0 0 80 0
1 8000100c 1 0 7ffe 0
1 80001008 2 0 81828384 0
2 80001008 3 0 0 800e7ffe81828384
2 80001001 0 0 0 ffffffffffffffa5
2 80001001 0 1 0 00000000000000a5
2 80001000 0 0 0 0000000000000011
2 80001002 1 0 0 ffffffffffffbeef
2 80001006 1 1 0 000000000000cafe
2 80001004 2 0 0 ffffffffcafef00d
2 80001000 2 1 0 00000000beefa511
2 80001000 2 0 0 ffffffffbeefa511
2 8000100f 0 0 0 ffffffffffffff80
2 8000100e 0 0 0 000000000000000e
2 8000100c 1 0 0 0000000000007ffe
2 80001008 1 0 0 ffffffffffff8384
2 8000100c 2 0 0 ffffffff800e7ffe
2 80001008 2 1 0 0000000081828384
4 80000040 0 0 1 0
3 0 0 0 6 0
4 80000104 0 0 0 0
3 0 0 0 5 0
5 80001040 0 0 8 0
4 80000000 0 0 1 0
6 80001040 0 0 c 0
6 80001040 0 0 c 0
0 0 0 0 0 0

/* testbench/tb_mem_subsystem.sv */
// memory slice testbench
`timescale 1ns/1ps
`include "mem_defines.svh"

module tb_mem_subsystem
	import mem_pkg::*;
();

	localparam int CLK_PERIOD = 8;
	localparam int MAX_VECTORS = 64;
	localparam int FIELDS = 6;
	localparam int MODEL_BYTES = 8 * (2 ** `RAM_INDEX_BITS);
	localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

	// vector operations
	localparam int OP_END = 0;
	localparam int OP_STORE = 1;
	localparam int OP_LOAD = 2;
	localparam int OP_FETCH = 3;
	localparam int OP_REDIRECT = 4;
	localparam int OP_FILL = 5;
	localparam int OP_STRESS = 6;

	logic                   clock = 1'b0;
	logic                   reset;
	logic                   fetch_en;
	logic                   redirect;
	logic [`XLEN-1:0]       redirect_pc;
	logic                   inst_valid;
	logic [`INST_WIDTH-1:0] inst;
	logic [`XLEN-1:0]       inst_pc;
	logic                   data_req;
	logic                   data_we;
	logic [`XLEN-1:0]       data_addr;
	mem_size_t              data_size;
	logic                   data_unsigned;
	logic [`XLEN-1:0]       data_wdata;
	logic                   load_valid;
	logic [`XLEN-1:0]       load_data;

	logic [63:0] vec_words [0:MAX_VECTORS*FIELDS-1];
	int          num_vectors = 0;
	logic        vectors_loaded = 1'b0;
	int          cycle_count = 0;
	logic [31:0] lfsr_state = 32'd70879;

	// reference model of memory bytes and pc
	logic [7:0]       model_mem [0:MODEL_BYTES-1];
	logic [`XLEN-1:0] model_pc;

	// expected results in issue order
	logic [`XLEN-1:0]       fetch_pc_q[$];
	logic [`INST_WIDTH-1:0] fetch_inst_q[$];
	int                     fetch_due_q[$];
	logic [`XLEN-1:0]       load_q[$];
	int                     load_due_q[$];

	mem_subsystem u_dut (
		.clock, .reset, .fetch_en, .redirect, .redirect_pc,
		.inst_valid, .inst, .inst_pc,
		.data_req, .data_we, .data_addr, .data_size, .data_unsigned, .data_wdata,
		.load_valid, .load_data
	);

	initial begin
		forever #(CLK_PERIOD / 2) clock = ~clock;
	end

	always @(posedge clock) begin
		cycle_count <= cycle_count + 1;
	end

	task automatic abort_run();
		$display("TEST FAILED");
		$fatal(1, "simulation stopped on the first error");
	endtask

	task automatic check_value(input logic [63:0] actual, input logic [63:0] expected,
			input string what);
		if (actual !== expected) begin
			$display("CHECK FAILED at %0t: %s, got %h, expected %h",
				$time, what, actual, expected);
			abort_run();
		end
	endtask

	function automatic logic [31:0] lfsr_step(input logic [31:0] state);
		logic [31:0] next;
		next = state >> 1;
		if (state[0]) begin
			next = next ^ LFSR_TAPS;
		end
		return next;
	endfunction

	// one step per bit taken
	task automatic random_bits(input int count, output logic [63:0] value);
		value = '0;
		for (int i = 0; i < count; i++) begin
			value[i] = lfsr_state[0];
			lfsr_state = lfsr_step(lfsr_state);
		end
	endtask

	// little endian read with the sign from the top loaded byte
	function automatic logic [`XLEN-1:0] model_load(input logic [`XLEN-1:0] addr,
			input logic [1:0] size, input logic is_unsigned);
		logic [`XLEN-1:0] value;
		int nbytes;
		int base;
		value = '0;
		nbytes = 1 << size;
		base = int'(addr - `PC_START);
		for (int i = 0; i < nbytes; i++) begin
			value[i*8 +: 8] = model_mem[base + i];
		end
		if (!is_unsigned && value[nbytes*8-1]) begin
			for (int i = nbytes * 8; i < `XLEN; i++) begin
				value[i] = 1'b1;
			end
		end
		return value;
	endfunction

	task automatic model_store(input logic [`XLEN-1:0] addr, input logic [1:0] size,
			input logic [`XLEN-1:0] wdata);
		int base;
		base = int'(addr - `PC_START);
		for (int i = 0; i < (1 << size); i++) begin
			model_mem[base + i] = wdata[i*8 +: 8];
		end
	endtask

	// drive one cycle and queue what it must return
	task automatic issue_cycle(input logic fetch, input logic redir,
			input logic [`XLEN-1:0] target, input logic req, input logic we,
			input logic [`XLEN-1:0] addr, input logic [1:0] size, input logic uns,
			input logic [`XLEN-1:0] wdata);
		logic [`XLEN-1:0]       used_pc;
		logic [`INST_WIDTH-1:0] word;
		int                     base;
		fetch_en = fetch;
		redirect = redir;
		redirect_pc = target;
		data_req = req;
		data_we = we;
		data_addr = addr;
		data_size = mem_size_t'(size);
		data_unsigned = uns;
		data_wdata = wdata;
		used_pc = redir ? target : model_pc;
		if (req && we) begin
			model_store(addr, size, wdata);
		end else if (req) begin
			load_q.push_back(model_load(addr, size, uns));
			load_due_q.push_back(cycle_count + 1);
		end
		// fetch only runs in cycles free of data
		if (fetch && !req) begin
			base = int'(used_pc - `PC_START);
			for (int i = 0; i < 4; i++) begin
				word[i*8 +: 8] = model_mem[base + i];
			end
			fetch_pc_q.push_back(used_pc);
			fetch_inst_q.push_back(word);
			fetch_due_q.push_back(cycle_count + 1);
			model_pc = used_pc + 4;
		end else begin
			model_pc = used_pc;
		end
		@(posedge clock);
		#1;
	endtask

	task automatic idle_cycle();
		issue_cycle(1'b0, 1'b0, '0, 1'b0, 1'b0, '0, 2'd0, 1'b0, '0);
	endtask

	task automatic idle_fetch();
		issue_cycle(1'b1, 1'b0, '0, 1'b0, 1'b0, '0, 2'd0, 1'b0, '0);
	endtask

	task automatic fill_words(input logic [`XLEN-1:0] base, input int count);
		logic [63:0] value;
		for (int i = 0; i < count; i++) begin
			random_bits(64, value);
			issue_cycle(1'b0, 1'b0, '0, 1'b1, 1'b1, base + 8 * i, 2'd3, 1'b0, value);
		end
	endtask

	// random accesses into eight words at base with fetch enabled
	task automatic stress_run(input logic [`XLEN-1:0] base, input int count);
		logic [63:0]      gap;
		logic [63:0]      we;
		logic [63:0]      size;
		logic [63:0]      word;
		logic [63:0]      offset;
		logic [63:0]      uns;
		logic [63:0]      value;
		logic [`XLEN-1:0] addr;
		for (int i = 0; i < count; i++) begin
			random_bits(3, gap);
			repeat (int'(gap)) idle_fetch();
			random_bits(1, we);
			random_bits(2, size);
			random_bits(3, word);
			random_bits(3, offset);
			random_bits(1, uns);
			random_bits(64, value);
			// natural alignment keeps the access inside one word
			offset = offset & ~((64'd1 << size) - 1);
			addr = base + 8 * word + offset;
			issue_cycle(1'b1, 1'b0, '0, 1'b1, we[0], addr, size[1:0], uns[0], value);
		end
	endtask

	always @(negedge clock) begin
		if (inst_valid !== 1'b0) begin
			check_value(inst_valid, 1'b1, "inst_valid level");
			if (fetch_pc_q.size() == 0) begin
				$display("inst_valid pulsed at %0t with no fetch outstanding", $time);
				abort_run();
			end
			check_value(cycle_count, fetch_due_q.pop_front(), "fetch latency");
			check_value(inst_pc, fetch_pc_q.pop_front(), "inst_pc");
			check_value(inst, fetch_inst_q.pop_front(), "inst");
		end
		if (load_valid !== 1'b0) begin
			check_value(load_valid, 1'b1, "load_valid level");
			if (load_q.size() == 0) begin
				$display("load_valid pulsed at %0t with no load outstanding", $time);
				abort_run();
			end
			check_value(cycle_count, load_due_q.pop_front(), "load latency");
			check_value(load_data, load_q.pop_front(), "load_data");
		end
		// anything due now and not seen is lost
		if (fetch_due_q.size() > 0 && fetch_due_q[0] <= cycle_count) begin
			$display("fetch of pc %h did not return at %0t", fetch_pc_q[0], $time);
			abort_run();
		end
		if (load_due_q.size() > 0 && load_due_q[0] <= cycle_count) begin
			$display("load result did not return at %0t", $time);
			abort_run();
		end
	end

	initial begin
		wait (vectors_loaded);
		repeat (num_vectors * 20 + 200) @(posedge clock);
		$display("run timed out after %0d cycles", num_vectors * 20 + 200);
		abort_run();
	end

	initial begin
		logic [63:0] op;
		logic [63:0] addr;
		logic [63:0] size_field;
		logic [63:0] uns_field;
		logic [63:0] data;
		logic [63:0] expected;
		reset = 1'b1;
		// requests during reset must not produce results
		fetch_en = 1'b1;
		redirect = 1'b0;
		redirect_pc = '0;
		data_req = 1'b0;
		data_we = 1'b0;
		data_addr = `PC_START;
		data_size = SIZE_BYTE;
		data_unsigned = 1'b0;
		data_wdata = '0;
		model_pc = `PC_START;
		$readmemh("testbench/mem_vectors.hex", vec_words);
		while (num_vectors < MAX_VECTORS && vec_words[num_vectors * FIELDS] !== OP_END) begin
			num_vectors++;
		end
		if (num_vectors == 0 || num_vectors == MAX_VECTORS) begin
			$display("vector file is missing, empty or has no end line");
			abort_run();
		end
		vectors_loaded = 1'b1;

		// valid outputs are watched by the monitor during reset
		repeat (5) @(posedge clock);
		#1;
		// loads take the port for the rest of reset
		data_req = 1'b1;
		repeat (5) @(posedge clock);
		#1;
		reset = 1'b0;
		idle_cycle();
		idle_cycle();

		for (int v = 0; v < num_vectors; v++) begin
			op = vec_words[v * FIELDS];
			addr = vec_words[v * FIELDS + 1];
			size_field = vec_words[v * FIELDS + 2];
			uns_field = vec_words[v * FIELDS + 3];
			data = vec_words[v * FIELDS + 4];
			expected = vec_words[v * FIELDS + 5];
			case (op)
				OP_STORE: begin
					issue_cycle(1'b0, 1'b0, '0, 1'b1, 1'b1, addr, size_field[1:0], 1'b0, data);
				end
				OP_LOAD: begin
					check_value(model_load(addr, size_field[1:0], uns_field[0]), expected,
						"vector file value against model");
					issue_cycle(1'b0, 1'b0, '0, 1'b1, 1'b0, addr, size_field[1:0],
						uns_field[0], '0);
				end
				OP_FETCH: begin
					repeat (int'(data)) idle_fetch();
				end
				OP_REDIRECT: begin
					issue_cycle(data[0], 1'b1, addr, 1'b0, 1'b0, '0, 2'd0, 1'b0, '0);
				end
				OP_FILL: fill_words(addr, int'(data));
				OP_STRESS: stress_run(addr, int'(data));
				default: begin
					$display("vector %0d has unknown operation %0h", v, op);
					abort_run();
				end
			endcase
		end

		// last results return one cycle after their request
		idle_cycle();
		idle_cycle();
		if (fetch_pc_q.size() == 0 && load_q.size() == 0) begin
			$display("TEST OK");
			$finish;
		end else begin
			$display("%0d fetches and %0d loads never returned",
				fetch_pc_q.size(), load_q.size());
			abort_run();
		end
	end

endmodule

/* verilog/mem_subsystem.sv */
// memory access slice top
`timescale 1ns/1ps
`include "mem_defines.svh"

module mem_subsystem
	import mem_pkg::*;
(
	input  logic                   clock,
	input  logic                   reset,
	input  logic                   fetch_en,
	input  logic                   redirect,
	input  logic [`XLEN-1:0]       redirect_pc,
	output logic                   inst_valid,
	output logic [`INST_WIDTH-1:0] inst,
	output logic [`XLEN-1:0]       inst_pc,
	input  logic                   data_req,
	input  logic                   data_we,
	input  logic [`XLEN-1:0]       data_addr,
	input  mem_size_t              data_size,
	input  logic                   data_unsigned,
	input  logic [`XLEN-1:0]       data_wdata,
	output logic                   load_valid,
	output logic [`XLEN-1:0]       load_data
);

	// fetch port
	logic                       fetch_req;
	logic [`RAM_INDEX_BITS-1:0] fetch_index;
	logic                       fetch_granted;
	logic [`XLEN-1:0]           fetch_rdata;

	// data port
	logic                       mem_req;
	logic                       mem_we;
	logic [`RAM_INDEX_BITS-1:0] mem_index;
	logic [`XLEN-1:0]           mem_wdata;
	logic [`XLEN-1:0]           mem_wmask;
	logic [`XLEN-1:0]           mem_rdata;

	// shared RAM port
	logic                       ram_en;
	logic                       ram_we;
	logic [`RAM_INDEX_BITS-1:0] ram_index;
	logic [`XLEN-1:0]           ram_wdata;
	logic [`XLEN-1:0]           ram_wmask;
	logic [`XLEN-1:0]           ram_rdata;

	inst_fetch u_fetch (
		.clock, .reset, .fetch_en, .redirect, .redirect_pc,
		.fetch_req, .fetch_index, .fetch_granted, .fetch_rdata,
		.inst_valid, .inst, .inst_pc
	);

	load_store_unit u_lsu (
		.clock, .reset, .data_req, .data_we, .data_addr, .data_size,
		.data_unsigned, .data_wdata,
		.mem_req, .mem_we, .mem_index, .mem_wdata, .mem_wmask, .mem_rdata,
		.load_valid, .load_data
	);

	mem_arbiter u_arbiter (
		.clock, .reset,
		.fetch_req, .fetch_index, .fetch_granted, .fetch_rdata,
		.mem_req, .mem_we, .mem_index, .mem_wdata, .mem_wmask, .mem_rdata,
		.ram_en, .ram_we, .ram_index, .ram_wdata, .ram_wmask, .ram_rdata
	);

	unified_ram u_ram (
		.clock, .ram_en, .ram_we, .ram_index, .ram_wdata, .ram_wmask, .ram_rdata
	);

endmodule

/* verilog/load_store_unit.sv */
// store alignment and load extension
`timescale 1ns/1ps
`include "mem_defines.svh"

module load_store_unit
	import mem_pkg::*;
(
	input  logic                       clock,
	input  logic                       reset,
	input  logic                       data_req,
	input  logic                       data_we,
	input  logic [`XLEN-1:0]           data_addr,
	input  mem_size_t                  data_size,
	input  logic                       data_unsigned,
	input  logic [`XLEN-1:0]           data_wdata,
	output logic                       mem_req,
	output logic                       mem_we,
	output logic [`RAM_INDEX_BITS-1:0] mem_index,
	output logic [`XLEN-1:0]           mem_wdata,
	output logic [`XLEN-1:0]           mem_wmask,
	input  logic [`XLEN-1:0]           mem_rdata,
	output logic                       load_valid,
	output logic [`XLEN-1:0]           load_data
);

	localparam int BYTES = `XLEN / 8;

	logic [`XLEN-1:0] addr_offset;
	logic [2:0]       byte_offset;
	logic [5:0]       shift_bits;
	logic [BYTES-1:0] base_en;
	logic [BYTES-1:0] byte_en;

	mem_size_t        size_q;
	logic             unsigned_q;
	logic [2:0]       offset_q;
	logic [`XLEN-1:0] shifted;
	logic             sign_ext;

	assign addr_offset = data_addr - `PC_START;
	assign byte_offset = data_addr[2:0];
	assign shift_bits  = {byte_offset, 3'b000};

	assign mem_req   = data_req;
	assign mem_we    = data_we;
	assign mem_index = addr_offset[`RAM_INDEX_BITS+2:3];
	assign mem_wdata = data_wdata << shift_bits;

	always_comb begin
		case (data_size)
			SIZE_BYTE: base_en = 8'h01;
			SIZE_HALF: base_en = 8'h03;
			SIZE_WORD: base_en = 8'h0f;
			default:   base_en = 8'hff;
		endcase
	end

	// accesses never cross the word, so nothing shifts out
	assign byte_en = base_en << byte_offset;

	always_comb begin
		for (int i = 0; i < BYTES; i++) begin
			mem_wmask[i*8 +: 8] = {8{byte_en[i]}};
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			load_valid <= 1'b0;
		end else begin
			load_valid <= data_req & ~data_we;
		end
	end

	// extraction info for the returning word
	always_ff @(posedge clock) begin
		if (data_req) begin
			size_q     <= data_size;
			unsigned_q <= data_unsigned;
			offset_q   <= byte_offset;
		end
	end

	assign shifted  = mem_rdata >> {offset_q, 3'b000};
	assign sign_ext = ~unsigned_q;

	always_comb begin
		case (size_q)
			SIZE_BYTE: load_data = {{(`XLEN-8){sign_ext & shifted[7]}}, shifted[7:0]};
			SIZE_HALF: load_data = {{(`XLEN-16){sign_ext & shifted[15]}}, shifted[15:0]};
			SIZE_WORD: load_data = {{(`XLEN-32){sign_ext & shifted[31]}}, shifted[31:0]};
			default:   load_data = shifted;
		endcase
	end

endmodule

/* verilog/inst_fetch.sv */
// program counter and instruction select
`timescale 1ns/1ps
`include "mem_defines.svh"

module inst_fetch (
	input  logic                       clock,
	input  logic                       reset,
	input  logic                       fetch_en,
	input  logic                       redirect,
	input  logic [`XLEN-1:0]           redirect_pc,
	output logic                       fetch_req,
	output logic [`RAM_INDEX_BITS-1:0] fetch_index,
	input  logic                       fetch_granted,
	input  logic [`XLEN-1:0]           fetch_rdata,
	output logic                       inst_valid,
	output logic [`INST_WIDTH-1:0]     inst,
	output logic [`XLEN-1:0]           inst_pc
);

	logic [`XLEN-1:0] pc;
	logic [`XLEN-1:0] cur_pc;
	logic [`XLEN-1:0] pc_offset;
	logic [`XLEN-1:0] next_pc;

	// a redirect takes effect in its own cycle
	assign cur_pc    = redirect ? redirect_pc : pc;
	assign pc_offset = cur_pc - `PC_START;
	assign next_pc   = cur_pc + `XLEN'd4;

	assign fetch_req   = fetch_en;
	assign fetch_index = pc_offset[`RAM_INDEX_BITS+2:3];

	always_ff @(posedge clock) begin
		if (reset) begin
			pc <= `PC_START;
		end else if (fetch_granted) begin
			pc <= next_pc;
		end else if (redirect) begin
			// no fetch this cycle, keep the target
			pc <= redirect_pc;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			inst_valid <= 1'b0;
		end else begin
			inst_valid <= fetch_granted;
		end
	end

	// pc of the word in flight
	always_ff @(posedge clock) begin
		if (fetch_granted) begin
			inst_pc <= cur_pc;
		end
	end

	// pc bit 2 picks the upper half
	assign inst = inst_pc[2] ? fetch_rdata[`XLEN-1:`INST_WIDTH]
		: fetch_rdata[`INST_WIDTH-1:0];

endmodule

/* verilog/mem_arbiter.sv */
// data over fetch RAM port arbiter
`timescale 1ns/1ps
`include "mem_defines.svh"

module mem_arbiter
	import mem_pkg::*;
(
	input  logic                       clock,
	input  logic                       reset,
	input  logic                       fetch_req,
	input  logic [`RAM_INDEX_BITS-1:0] fetch_index,
	output logic                       fetch_granted,
	output logic [`XLEN-1:0]           fetch_rdata,
	input  logic                       mem_req,
	input  logic                       mem_we,
	input  logic [`RAM_INDEX_BITS-1:0] mem_index,
	input  logic [`XLEN-1:0]           mem_wdata,
	input  logic [`XLEN-1:0]           mem_wmask,
	output logic [`XLEN-1:0]           mem_rdata,
	output logic                       ram_en,
	output logic                       ram_we,
	output logic [`RAM_INDEX_BITS-1:0] ram_index,
	output logic [`XLEN-1:0]           ram_wdata,
	output logic [`XLEN-1:0]           ram_wmask,
	input  logic [`XLEN-1:0]           ram_rdata
);

	grant_t grant;
	grant_t read_owner;

	// data always wins
	assign grant         = mem_req ? GRANT_DATA : GRANT_FETCH;
	assign fetch_granted = fetch_req & ~mem_req;

	assign ram_en    = mem_req | fetch_req;
	assign ram_we    = mem_req & mem_we;
	assign ram_index = (grant == GRANT_DATA) ? mem_index : fetch_index;
	assign ram_wdata = mem_wdata;
	assign ram_wmask = (grant == GRANT_DATA) ? mem_wmask : '0;

	// who owns the word coming back next cycle
	always_ff @(posedge clock) begin
		if (reset) begin
			read_owner <= GRANT_FETCH;
		end else if (ram_en) begin
			read_owner <= grant;
		end
	end

	assign fetch_rdata = (read_owner == GRANT_FETCH) ? ram_rdata : '0;
	assign mem_rdata   = (read_owner == GRANT_DATA) ? ram_rdata : '0;

endmodule

/* verilog/unified_ram.sv */
// byte-masked single port RAM
`timescale 1ns/1ps
`include "mem_defines.svh"

module unified_ram (
	input  logic                       clock,
	input  logic                       ram_en,
	input  logic                       ram_we,
	input  logic [`RAM_INDEX_BITS-1:0] ram_index,
	input  logic [`XLEN-1:0]           ram_wdata,
	input  logic [`XLEN-1:0]           ram_wmask,
	output logic [`XLEN-1:0]           ram_rdata
);

	localparam int DEPTH = 2 ** `RAM_INDEX_BITS;

	logic [`XLEN-1:0] mem [0:DEPTH-1];
	logic [`XLEN-1:0] merged;

	// keep unmasked bits of the stored word
	assign merged = (mem[ram_index] & ~ram_wmask) | (ram_wdata & ram_wmask);

	always_ff @(posedge clock) begin
		if (ram_en) begin
			if (ram_we) begin
				mem[ram_index] <= merged;
			end
			// read returns the old word on a write cycle
			ram_rdata <= mem[ram_index];
		end
	end

endmodule

/* verilog/mem_pkg.sv */
// memory slice shared types
package mem_pkg;

	// access size of a load or store
	typedef enum logic [1:0] {
		SIZE_BYTE   = 2'd0,
		SIZE_HALF   = 2'd1,
		SIZE_WORD   = 2'd2,
		SIZE_DOUBLE = 2'd3
	} mem_size_t;

	// owner of the single RAM port
	typedef enum logic {
		GRANT_FETCH = 1'b0,
		GRANT_DATA  = 1'b1
	} grant_t;

endpackage

/* verilog/mem_defines.svh */
// memory slice width and layout macros
`ifndef MEM_DEFINES_SVH
`define MEM_DEFINES_SVH

// data and address width
`define XLEN 64

// one instruction is half a data word
`define INST_WIDTH 32

// base of the RAM and the reset pc
`define PC_START 64'h0000_0000_8000_0000

// log2 of RAM depth in 64-bit words
`define RAM_INDEX_BITS 10

`endif
